// ==== Bender.yml ====
package:
  name: message_manager

sources:
  - lcd_pkg.sv
  - consumable_if.sv
  - status_screens.sv
  - selection_screens.sv
  - brew_screen.sv
  - message_select.sv
  - message_manager.sv
  - target: test
    files:
      - tb_message_manager.sv

// ==== brew_screen.sv ====
`timescale 1ns/1ns

module brew_screen #(
    parameter int unsigned BAR_FULL_SCALE = 100
) (
    input  logic [7:0]          brew_progress,
    input  logic                temp_ready,
    output lcd_pkg::lcd_frame_t brew_frame
);
    import lcd_pkg::*;

    int unsigned filled;
    lcd_line_t   bar;

    // Filled cells, rounded down and capped at the line width
    always_comb begin
        filled = (brew_progress * LCD_COLS) / BAR_FULL_SCALE;
        if (filled > LCD_COLS) begin
            filled = LCD_COLS;
        end
    end

    always_comb begin
        for (int unsigned i = 0; i < LCD_COLS; i++) begin
            bar[(LCD_COLS-1-i)*8 +: 8] = (i < filled) ? CHAR_HASH : CHAR_DASH;
        end
    end

    // Water still below brew temperature
    always_comb begin
        if (!temp_ready) begin
            brew_frame = '{str_to_line("Heating Water..."), str_to_line("Please Wait")};
        end else begin
            brew_frame = '{str_to_line("Brewing..."), bar};
        end
    end

endmodule

// ==== consumable_if.sv ====
`timescale 1ns/1ns

interface consumable_if;

    logic bin0_empty;
    logic bin0_low;
    logic bin1_empty;
    logic bin1_low;
    logic creamer_empty;
    logic chocolate_empty;
    logic paper_empty;

    modport source (
        output bin0_empty, bin0_low, bin1_empty, bin1_low,
        output creamer_empty, chocolate_empty, paper_empty
    );

    modport sink (
        input bin0_empty, bin0_low, bin1_empty, bin1_low,
        input creamer_empty, chocolate_empty, paper_empty
    );

endinterface

// ==== lcd_pkg.sv ====
package lcd_pkg;

    localparam int unsigned LCD_COLS = 16;

    typedef logic [LCD_COLS*8-1:0] lcd_line_t;

    typedef struct packed {
        lcd_line_t line1;
        lcd_line_t line2;
    } lcd_frame_t;

    // ============================================================
    // Encodings shared with the menu controller
    // ============================================================

    typedef enum logic [3:0] {
        ST_SPLASH       = 4'd0,
        ST_CHECK_ERRORS = 4'd1,
        ST_COFFEE_SEL   = 4'd2,
        ST_DRINK_SEL    = 4'd3,
        ST_SIZE_SEL     = 4'd4,
        ST_CONFIRM      = 4'd5,
        ST_BREWING      = 4'd6,
        ST_COMPLETE     = 4'd7,
        ST_SETTINGS     = 4'd8,
        ST_ERROR        = 4'd9,
        ST_INSUFFICIENT = 4'd10
    } menu_state_e;

    typedef enum logic [2:0] {
        DRINK_BLACK     = 3'd0,
        DRINK_ESPRESSO  = 3'd1,
        DRINK_LATTE     = 3'd2,
        DRINK_MOCHA     = 3'd3,
        DRINK_AMERICANO = 3'd4
    } drink_e;

    typedef enum logic [1:0] {
        SIZE_8OZ  = 2'd0,
        SIZE_12OZ = 2'd1,
        SIZE_16OZ = 2'd2
    } size_e;

    typedef enum logic [2:0] {
        BIN0 = 3'd0,
        BIN1 = 3'd1
    } coffee_bin_e;

    localparam logic [7:0] CHAR_SPACE = 8'h20;
    localparam logic [7:0] CHAR_HASH  = 8'h23;
    localparam logic [7:0] CHAR_DASH  = 8'h2d;
    localparam logic [7:0] CHAR_ZERO  = 8'h30;

    // ============================================================
    // Text helpers
    // ============================================================

    // Leftmost character lands in the top byte, short text padded with spaces
    function automatic lcd_line_t str_to_line(input string s);
        lcd_line_t line;
        line = {LCD_COLS{CHAR_SPACE}};
        for (int i = 0; i < LCD_COLS; i++) begin
            if (i < s.len()) begin
                line[(LCD_COLS-1-i)*8 +: 8] = s[i];
            end
        end
        return line;
    endfunction

    function automatic logic [7:0] digit_char(input logic [3:0] value);
        if (value <= 4'd9) begin
            return CHAR_ZERO + {4'd0, value};
        end
        return CHAR_SPACE;
    endfunction

endpackage

// ==== message_manager.sv ====
`timescale 1ns/1ns

module message_manager #(
    parameter int unsigned BAR_FULL_SCALE = 100
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [3:0]                         current_menu_state,
    input  logic [2:0]                         selected_coffee_type,
    input  logic [2:0]                         selected_drink_type,
    input  logic [1:0]                         selected_size,
    input  logic [7:0]                         brew_progress,
    input  logic [3:0]                         warning_count,
    input  logic [3:0]                         error_count,
    input  logic                               error_present,
    input  logic                               can_make_coffee,
    input  logic                               bin0_empty,
    input  logic                               bin0_low,
    input  logic                               bin1_empty,
    input  logic                               bin1_low,
    input  logic                               creamer_empty,
    input  logic                               chocolate_empty,
    input  logic                               paper_empty,
    input  logic                               temp_ready,
    input  logic                               pressure_ready,
    output logic [lcd_pkg::LCD_COLS*8-1:0]     line1_text,
    output logic [lcd_pkg::LCD_COLS*8-1:0]     line2_text,
    output logic                               message_updated
);
    import lcd_pkg::*;

    lcd_frame_t splash_frame, check_frame, insufficient_frame, error_frame;
    lcd_frame_t complete_frame, settings_frame;
    lcd_frame_t coffee_frame, drink_frame, size_frame, confirm_frame;
    lcd_frame_t brew_frame;

    // ============================================================
    // Consumable levels
    // ============================================================

    consumable_if levels ();

    assign levels.bin0_empty      = bin0_empty;
    assign levels.bin0_low        = bin0_low;
    assign levels.bin1_empty      = bin1_empty;
    assign levels.bin1_low        = bin1_low;
    assign levels.creamer_empty   = creamer_empty;
    assign levels.chocolate_empty = chocolate_empty;
    assign levels.paper_empty     = paper_empty;

    // ============================================================
    // Screen generators and output register
    // ============================================================

    status_screens u_status_screens (
        .levels               (levels.sink),
        .warning_count        (warning_count),
        .error_count          (error_count),
        .error_present        (error_present),
        .can_make_coffee      (can_make_coffee),
        .pressure_ready       (pressure_ready),
        .selected_coffee_type (coffee_bin_e'(selected_coffee_type)),
        .splash_frame         (splash_frame),
        .check_frame          (check_frame),
        .insufficient_frame   (insufficient_frame),
        .error_frame          (error_frame),
        .complete_frame       (complete_frame),
        .settings_frame       (settings_frame)
    );

    selection_screens u_selection_screens (
        .levels               (levels.sink),
        .selected_coffee_type (coffee_bin_e'(selected_coffee_type)),
        .selected_drink_type  (drink_e'(selected_drink_type)),
        .selected_size        (size_e'(selected_size)),
        .coffee_frame         (coffee_frame),
        .drink_frame          (drink_frame),
        .size_frame           (size_frame),
        .confirm_frame        (confirm_frame)
    );

    brew_screen #(
        .BAR_FULL_SCALE (BAR_FULL_SCALE)
    ) u_brew_screen (
        .brew_progress (brew_progress),
        .temp_ready    (temp_ready),
        .brew_frame    (brew_frame)
    );

    message_select u_message_select (
        .clk                (clk),
        .rst_n              (rst_n),
        .current_menu_state (menu_state_e'(current_menu_state)),
        .splash_frame       (splash_frame),
        .check_frame        (check_frame),
        .coffee_frame       (coffee_frame),
        .drink_frame        (drink_frame),
        .size_frame         (size_frame),
        .confirm_frame      (confirm_frame),
        .brew_frame         (brew_frame),
        .complete_frame     (complete_frame),
        .settings_frame     (settings_frame),
        .error_frame        (error_frame),
        .insufficient_frame (insufficient_frame),
        .line1_text         (line1_text),
        .line2_text         (line2_text),
        .message_updated    (message_updated)
    );

endmodule

// ==== message_select.sv ====
`timescale 1ns/1ns

module message_select (
    input  logic                 clk,
    input  logic                 rst_n,
    input  lcd_pkg::menu_state_e current_menu_state,
    input  lcd_pkg::lcd_frame_t  splash_frame,
    input  lcd_pkg::lcd_frame_t  check_frame,
    input  lcd_pkg::lcd_frame_t  coffee_frame,
    input  lcd_pkg::lcd_frame_t  drink_frame,
    input  lcd_pkg::lcd_frame_t  size_frame,
    input  lcd_pkg::lcd_frame_t  confirm_frame,
    input  lcd_pkg::lcd_frame_t  brew_frame,
    input  lcd_pkg::lcd_frame_t  complete_frame,
    input  lcd_pkg::lcd_frame_t  settings_frame,
    input  lcd_pkg::lcd_frame_t  error_frame,
    input  lcd_pkg::lcd_frame_t  insufficient_frame,
    output lcd_pkg::lcd_line_t   line1_text,
    output lcd_pkg::lcd_line_t   line2_text,
    output logic                 message_updated
);
    import lcd_pkg::*;

    lcd_frame_t next_frame;

    always_comb begin
        case (current_menu_state)
            ST_SPLASH:       next_frame = splash_frame;
            ST_CHECK_ERRORS: next_frame = check_frame;
            ST_COFFEE_SEL:   next_frame = coffee_frame;
            ST_DRINK_SEL:    next_frame = drink_frame;
            ST_SIZE_SEL:     next_frame = size_frame;
            ST_CONFIRM:      next_frame = confirm_frame;
            ST_BREWING:      next_frame = brew_frame;
            ST_COMPLETE:     next_frame = complete_frame;
            ST_SETTINGS:     next_frame = settings_frame;
            ST_ERROR:        next_frame = error_frame;
            ST_INSUFFICIENT: next_frame = insufficient_frame;
            default: next_frame = '{str_to_line("System Error"), str_to_line("Unknown State")};
        endcase
    end

    // Flag compares the new text against what the panel holds now
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line1_text      <= {LCD_COLS{CHAR_SPACE}};
            line2_text      <= {LCD_COLS{CHAR_SPACE}};
            message_updated <= 1'b0;
        end else begin
            line1_text      <= next_frame.line1;
            line2_text      <= next_frame.line2;
            message_updated <= (next_frame.line1 != line1_text) ||
                               (next_frame.line2 != line2_text);
        end
    end

endmodule

// ==== selection_screens.sv ====
`timescale 1ns/1ns

module selection_screens (
    consumable_if.sink           levels,
    input  lcd_pkg::coffee_bin_e selected_coffee_type,
    input  lcd_pkg::drink_e      selected_drink_type,
    input  lcd_pkg::size_e       selected_size,
    output lcd_pkg::lcd_frame_t  coffee_frame,
    output lcd_pkg::lcd_frame_t  drink_frame,
    output lcd_pkg::lcd_frame_t  size_frame,
    output lcd_pkg::lcd_frame_t  confirm_frame
);
    import lcd_pkg::*;

    // Any code other than bin 0 shows as the second bin
    always_comb begin
        if (selected_coffee_type == BIN0) begin
            coffee_frame.line1 = str_to_line("Coffee Bin: [1]");
            if (levels.bin0_empty) begin
                coffee_frame.line2 = str_to_line("EMPTY! Try Bin2");
            end else if (levels.bin0_low) begin
                coffee_frame.line2 = str_to_line("LOW <-> Select");
            end else begin
                coffee_frame.line2 = str_to_line("<-> Select");
            end
        end else begin
            coffee_frame.line1 = str_to_line("Coffee Bin: [2]");
            if (levels.bin1_empty) begin
                coffee_frame.line2 = str_to_line("EMPTY! Try Bin1");
            end else if (levels.bin1_low) begin
                coffee_frame.line2 = str_to_line("LOW <-> Select");
            end else begin
                coffee_frame.line2 = str_to_line("<-> Select");
            end
        end
    end

    always_comb begin
        case (selected_drink_type)
            DRINK_BLACK:     drink_frame.line1 = str_to_line("Drink: [Black]");
            DRINK_ESPRESSO:  drink_frame.line1 = str_to_line("Drink:[Esprso]");
            DRINK_LATTE:     drink_frame.line1 = str_to_line("Drink: [Latte]");
            DRINK_MOCHA:     drink_frame.line1 = str_to_line("Drink: [Mocha]");
            DRINK_AMERICANO: drink_frame.line1 = str_to_line("Drink:[Amrcno]");
            default:         drink_frame.line1 = str_to_line("Drink: ?");
        endcase
        drink_frame.line2 = str_to_line("<-> Select");
    end

    always_comb begin
        case (selected_size)
            SIZE_8OZ:  size_frame.line1 = str_to_line("Size: [8oz]");
            SIZE_12OZ: size_frame.line1 = str_to_line("Size: [12oz]");
            SIZE_16OZ: size_frame.line1 = str_to_line("Size: [16oz]");
            default:   size_frame.line1 = str_to_line("Size: ?");
        endcase
        size_frame.line2 = str_to_line("<-> Select");
    end

    // ============================================================
    // Order summary, blank for any undefined drink or size
    // ============================================================

    always_comb begin
        confirm_frame.line1 = str_to_line("");
        case (selected_drink_type)
            DRINK_BLACK: case (selected_size)
                SIZE_8OZ:  confirm_frame.line1 = str_to_line("Black Coffee 8z");
                SIZE_12OZ: confirm_frame.line1 = str_to_line("Black Coffee12z");
                SIZE_16OZ: confirm_frame.line1 = str_to_line("Black Coffee16z");
                default:   confirm_frame.line1 = str_to_line("");
            endcase
            DRINK_ESPRESSO: case (selected_size)
                SIZE_8OZ:  confirm_frame.line1 = str_to_line("Coffee+Cream 8z");
                SIZE_12OZ: confirm_frame.line1 = str_to_line("Coffee+Cream12z");
                SIZE_16OZ: confirm_frame.line1 = str_to_line("Coffee+Cream16z");
                default:   confirm_frame.line1 = str_to_line("");
            endcase
            DRINK_LATTE: case (selected_size)
                SIZE_8OZ:  confirm_frame.line1 = str_to_line("Latte 8oz");
                SIZE_12OZ: confirm_frame.line1 = str_to_line("Latte 12oz");
                SIZE_16OZ: confirm_frame.line1 = str_to_line("Latte 16oz");
                default:   confirm_frame.line1 = str_to_line("");
            endcase
            DRINK_MOCHA: case (selected_size)
                SIZE_8OZ:  confirm_frame.line1 = str_to_line("Mocha 8oz");
                SIZE_12OZ: confirm_frame.line1 = str_to_line("Mocha 12oz");
                SIZE_16OZ: confirm_frame.line1 = str_to_line("Mocha 16oz");
                default:   confirm_frame.line1 = str_to_line("");
            endcase
            DRINK_AMERICANO: case (selected_size)
                SIZE_8OZ:  confirm_frame.line1 = str_to_line("Hot Choco 8oz");
                SIZE_12OZ: confirm_frame.line1 = str_to_line("Hot Choco 12oz");
                SIZE_16OZ: confirm_frame.line1 = str_to_line("Hot Choco 16oz");
                default:   confirm_frame.line1 = str_to_line("");
            endcase
            default: confirm_frame.line1 = str_to_line("");
        endcase
        confirm_frame.line2 = str_to_line("Start? Cancel?");
    end

endmodule

// ==== status_screens.sv ====
`timescale 1ns/1ns

module status_screens (
    consumable_if.sink           levels,
    input  logic [3:0]           warning_count,
    input  logic [3:0]           error_count,
    input  logic                 error_present,
    input  logic                 can_make_coffee,
    input  logic                 pressure_ready,
    input  lcd_pkg::coffee_bin_e selected_coffee_type,
    output lcd_pkg::lcd_frame_t  splash_frame,
    output lcd_pkg::lcd_frame_t  check_frame,
    output lcd_pkg::lcd_frame_t  insufficient_frame,
    output lcd_pkg::lcd_frame_t  error_frame,
    output lcd_pkg::lcd_frame_t  complete_frame,
    output lcd_pkg::lcd_frame_t  settings_frame
);
    import lcd_pkg::*;

    // Digit positions in "W:x E:y Press->"
    localparam int unsigned WARN_COL = 2;
    localparam int unsigned ERR_COL  = 6;

    always_comb begin
        splash_frame.line1 = str_to_line("Coffee Machine");
        if (error_present || warning_count != 4'd0) begin
            splash_frame.line2 = str_to_line("W:x E:y Press->");
            splash_frame.line2[(LCD_COLS-1-WARN_COL)*8 +: 8] = digit_char(warning_count);
            splash_frame.line2[(LCD_COLS-1-ERR_COL)*8 +: 8]  = digit_char(error_count);
        end else begin
            splash_frame.line2 = str_to_line("Press Start");
        end
    end

    // Pre-brew check, first failing condition wins
    always_comb begin
        if (levels.paper_empty) begin
            check_frame = '{str_to_line("Not Enough:"), str_to_line("Paper Filter!")};
        end else if (!can_make_coffee) begin
            check_frame = '{str_to_line("Not Enough:"), str_to_line("Coffee!")};
        end else if (levels.creamer_empty) begin
            check_frame = '{str_to_line("Not Enough:"), str_to_line("Creamer!")};
        end else if (levels.chocolate_empty) begin
            check_frame = '{str_to_line("Not Enough:"), str_to_line("Chocolate!")};
        end else if (!pressure_ready) begin
            check_frame = '{str_to_line("Water System"), str_to_line("Pressure Error!")};
        end else begin
            check_frame = '{str_to_line("Checking..."), str_to_line("Please wait")};
        end
    end

    always_comb begin
        insufficient_frame.line1 = str_to_line("Not Enough:");
        if (levels.bin0_empty && selected_coffee_type == BIN0) begin
            insufficient_frame.line2 = str_to_line("Bin 0 Coffee!");
        end else if (levels.bin1_empty && selected_coffee_type == BIN1) begin
            insufficient_frame.line2 = str_to_line("Bin 1 Coffee!");
        end else if (levels.creamer_empty) begin
            insufficient_frame.line2 = str_to_line("Creamer!");
        end else if (levels.chocolate_empty) begin
            insufficient_frame.line2 = str_to_line("Chocolate!");
        end else if (levels.paper_empty) begin
            insufficient_frame.line2 = str_to_line("Paper Filter!");
        end else begin
            insufficient_frame.line2 = str_to_line("Ingredients!");
        end
    end

    // ============================================================
    // Fault screen
    // ============================================================

    always_comb begin
        if (!pressure_ready) begin
            error_frame = '{str_to_line("ERR: No Water"), str_to_line("Check Pressure!")};
        end else if (levels.paper_empty) begin
            error_frame = '{str_to_line("ERR: No Paper"), str_to_line("Refill Filter!")};
        end else if (levels.bin0_empty && levels.bin1_empty) begin
            error_frame = '{str_to_line("ERR: No Coffee"), str_to_line("Refill Bins!")};
        end else begin
            error_frame = '{str_to_line("SYSTEM ERROR"), str_to_line("Press Cancel")};
        end
    end

    assign complete_frame = '{str_to_line("Enjoy Your"), str_to_line("Beverage!")};
    assign settings_frame = '{str_to_line("Settings Mode"), str_to_line("Cancel to exit")};

endmodule

// ==== tb_message_manager.sv ====
`timescale 1ns/1ns

module tb_message_manager;

    localparam int BAR_SCALE = 100;
    // Reset, splash, coffee, drink/size/confirm, brew, status, fixed/unknown, hold
    localparam int STIM_CYCLES = 5 + 21 + 24 + 44 + 40 + 112 + 7 + 3;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 50;
    localparam logic [127:0] SPACES = {16{8'h20}};

    logic         clk;
    logic         rst_n;
    logic [3:0]   current_menu_state;
    logic [2:0]   selected_coffee_type;
    logic [2:0]   selected_drink_type;
    logic [1:0]   selected_size;
    logic [7:0]   brew_progress;
    logic [3:0]   warning_count;
    logic [3:0]   error_count;
    logic         error_present;
    logic         can_make_coffee;
    logic         bin0_empty;
    logic         bin0_low;
    logic         bin1_empty;
    logic         bin1_low;
    logic         creamer_empty;
    logic         chocolate_empty;
    logic         paper_empty;
    logic         temp_ready;
    logic         pressure_ready;
    logic [127:0] line1_text;
    logic [127:0] line2_text;
    logic         message_updated;

    logic [127:0] exp_line1;
    logic [127:0] exp_line2;
    logic         exp_updated;
    int           seed;
    int           cycle_count;
    int           rnd;

    string drink_text [0:7] = '{"Drink: [Black]", "Drink:[Esprso]", "Drink: [Latte]",
        "Drink: [Mocha]", "Drink:[Amrcno]", "Drink: ?", "Drink: ?", "Drink: ?"};
    string size_text [0:3] = '{"Size: [8oz]", "Size: [12oz]", "Size: [16oz]", "Size: ?"};
    string order_name [0:4] = '{"Black Coffee", "Coffee+Cream", "Latte", "Mocha", "Hot Choco"};
    string long_tag [0:2] = '{" 8z", "12z", "16z"};
    string short_tag [0:2] = '{" 8oz", " 12oz", " 16oz"};
    int    fixed_progress [0:5] = '{0, 6, 7, 99, 100, 255};

    message_manager #(
        .BAR_FULL_SCALE (BAR_SCALE)
    ) u_message_manager (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: test still running after %0d clock cycles", TIMEOUT_CYCLES);
            report_failure();
        end
    end

    // ============================================================
    // Reference text
    // ============================================================

    function automatic logic [127:0] to_line(input string s);
        logic [127:0] line;
        line = '0;
        for (int i = 0; i < 16; i++) begin
            if (i < s.len()) line = {line[119:0], s[i]};
            else line = {line[119:0], 8'h20};
        end
        return line;
    endfunction

    function automatic string count_char(input logic [3:0] value);
        if (value < 4'd10) return $sformatf("%0d", value);
        return " ";
    endfunction

    function automatic logic [255:0] expected_text();
        string l1;
        string l2;
        int    n;
        l1 = "";
        l2 = "";
        case (current_menu_state)
            4'd0: begin
                l1 = "Coffee Machine";
                if (error_present || warning_count != 4'd0) begin
                    l2 = {"W:", count_char(warning_count), " E:", count_char(error_count),
                          " Press->"};
                end else begin
                    l2 = "Press Start";
                end
            end
            4'd1: begin
                l1 = "Not Enough:";
                if (paper_empty) l2 = "Paper Filter!";
                else if (!can_make_coffee) l2 = "Coffee!";
                else if (creamer_empty) l2 = "Creamer!";
                else if (chocolate_empty) l2 = "Chocolate!";
                else if (!pressure_ready) l2 = "Pressure Error!";
                else l2 = "Please wait";
                if (l2 == "Pressure Error!") l1 = "Water System";
                if (l2 == "Please wait") l1 = "Checking...";
            end
            4'd2: begin
                if (selected_coffee_type == 3'd0) begin
                    l1 = "Coffee Bin: [1]";
                    if (bin0_empty) l2 = "EMPTY! Try Bin2";
                    else if (bin0_low) l2 = "LOW <-> Select";
                    else l2 = "<-> Select";
                end else begin
                    l1 = "Coffee Bin: [2]";
                    if (bin1_empty) l2 = "EMPTY! Try Bin1";
                    else if (bin1_low) l2 = "LOW <-> Select";
                    else l2 = "<-> Select";
                end
            end
            4'd3: begin
                l1 = drink_text[selected_drink_type];
                l2 = "<-> Select";
            end
            4'd4: begin
                l1 = size_text[selected_size];
                l2 = "<-> Select";
            end
            4'd5: begin
                // Names that fill twelve columns get the compact size tag
                if (selected_drink_type < 3'd5 && selected_size < 2'd3) begin
                    if (order_name[selected_drink_type].len() == 12) begin
                        l1 = {order_name[selected_drink_type], long_tag[selected_size]};
                    end else begin
                        l1 = {order_name[selected_drink_type], short_tag[selected_size]};
                    end
                end
                l2 = "Start? Cancel?";
            end
            4'd6: begin
                if (!temp_ready) begin
                    l1 = "Heating Water...";
                    l2 = "Please Wait";
                end else begin
                    l1 = "Brewing...";
                    n = int'(brew_progress) * 16 / BAR_SCALE;
                    if (n > 16) n = 16;
                    for (int i = 0; i < 16; i++) begin
                        if (i < n) l2 = {l2, "#"};
                        else l2 = {l2, "-"};
                    end
                end
            end
            4'd7: begin
                l1 = "Enjoy Your";
                l2 = "Beverage!";
            end
            4'd8: begin
                l1 = "Settings Mode";
                l2 = "Cancel to exit";
            end
            4'd9: begin
                if (!pressure_ready) begin
                    l1 = "ERR: No Water";
                    l2 = "Check Pressure!";
                end else if (paper_empty) begin
                    l1 = "ERR: No Paper";
                    l2 = "Refill Filter!";
                end else if (bin0_empty && bin1_empty) begin
                    l1 = "ERR: No Coffee";
                    l2 = "Refill Bins!";
                end else begin
                    l1 = "SYSTEM ERROR";
                    l2 = "Press Cancel";
                end
            end
            4'd10: begin
                l1 = "Not Enough:";
                if (bin0_empty && selected_coffee_type == 3'd0) l2 = "Bin 0 Coffee!";
                else if (bin1_empty && selected_coffee_type == 3'd1) l2 = "Bin 1 Coffee!";
                else if (creamer_empty) l2 = "Creamer!";
                else if (chocolate_empty) l2 = "Chocolate!";
                else if (paper_empty) l2 = "Paper Filter!";
                else l2 = "Ingredients!";
            end
            default: begin
                l1 = "System Error";
                l2 = "Unknown State";
            end
        endcase
        return {to_line(l1), to_line(l2)};
    endfunction

    // ============================================================
    // Drive and check
    // ============================================================

    task automatic report_failure();
        $display("Finished with errors");
        $fatal(1, "Stopping at the first failure");
    endtask

    task automatic check_outputs();
        assert (line1_text === exp_line1) else begin
            $display("ERROR: line1_text = %h, expected %h", line1_text, exp_line1);
            report_failure();
        end
        assert (line2_text === exp_line2) else begin
            $display("ERROR: line2_text = %h, expected %h", line2_text, exp_line2);
            report_failure();
        end
        assert (message_updated === exp_updated) else begin
            $display("ERROR: message_updated = %h, expected %h", message_updated, exp_updated);
            report_failure();
        end
    endtask

    // Inputs were set on this falling edge, outputs checked on the next one
    task automatic drive_cycle();
        logic [255:0] next_text;
        next_text = expected_text();
        exp_updated = (next_text != {exp_line1, exp_line2});
        {exp_line1, exp_line2} = next_text;
        @(negedge clk);
        check_outputs();
    endtask

    task automatic set_defaults();
        current_menu_state = 4'd0;
        selected_coffee_type = 3'd0;
        selected_drink_type = 3'd0;
        selected_size = 2'd0;
        brew_progress = 8'd0;
        warning_count = 4'd0;
        error_count = 4'd0;
        error_present = 1'b0;
        can_make_coffee = 1'b1;
        bin0_empty = 1'b0;
        bin0_low = 1'b0;
        bin1_empty = 1'b0;
        bin1_low = 1'b0;
        creamer_empty = 1'b0;
        chocolate_empty = 1'b0;
        paper_empty = 1'b0;
        temp_ready = 1'b1;
        pressure_ready = 1'b1;
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        seed = 57014;
        cycle_count = 0;
        set_defaults();
        exp_line1 = SPACES;
        exp_line2 = SPACES;
        exp_updated = 1'b0;
        repeat (5) begin
            @(negedge clk);
            check_outputs();
        end
        rst_n = 1'b1;

        // Splash
        drive_cycle();
        repeat (20) begin
            rnd = $random(seed);
            warning_count = rnd[3:0];
            error_count = rnd[7:4];
            error_present = rnd[8];
            drive_cycle();
        end

        // Bin selection, levels empty, low and normal
        set_defaults();
        current_menu_state = 4'd2;
        for (int code = 0; code < 8; code++) begin
            for (int lvl = 0; lvl < 3; lvl++) begin
                selected_coffee_type = code[2:0];
                // Other bin always one level further on
                bin0_empty = (lvl == 0);
                bin0_low = (lvl != 2);
                bin1_empty = (lvl == 2);
                bin1_low = (lvl != 1);
                drive_cycle();
            end
        end

        set_defaults();
        current_menu_state = 4'd3;
        for (int d = 0; d < 8; d++) begin
            selected_drink_type = d[2:0];
            drive_cycle();
        end
        current_menu_state = 4'd4;
        for (int s = 0; s < 4; s++) begin
            selected_size = s[1:0];
            drive_cycle();
        end
        current_menu_state = 4'd5;
        for (int d = 0; d < 8; d++) begin
            for (int s = 0; s < 4; s++) begin
                selected_drink_type = d[2:0];
                selected_size = s[1:0];
                drive_cycle();
            end
        end

        // Brewing, progress changes while heating leave the text alone
        set_defaults();
        current_menu_state = 4'd6;
        temp_ready = 1'b0;
        foreach (fixed_progress[i]) begin
            if (i < 4) begin
                brew_progress = 8'(fixed_progress[i] + 10);
                drive_cycle();
            end
        end
        temp_ready = 1'b1;
        foreach (fixed_progress[i]) begin
            brew_progress = 8'(fixed_progress[i]);
            drive_cycle();
        end
        repeat (30) begin
            rnd = $random(seed);
            brew_progress = rnd[7:0];
            drive_cycle();
        end

        // Every flag combination covers singles and pairs
        set_defaults();
        current_menu_state = 4'd1;
        for (int m = 0; m < 32; m++) begin
            paper_empty = m[0];
            can_make_coffee = !m[1];
            creamer_empty = m[2];
            chocolate_empty = m[3];
            pressure_ready = !m[4];
            drive_cycle();
        end
        set_defaults();
        current_menu_state = 4'd10;
        for (int m = 0; m < 64; m++) begin
            bin0_empty = m[0];
            bin1_empty = m[1];
            creamer_empty = m[2];
            chocolate_empty = m[3];
            paper_empty = m[4];
            selected_coffee_type = {2'b00, m[5]};
            drive_cycle();
        end
        set_defaults();
        current_menu_state = 4'd9;
        for (int m = 0; m < 16; m++) begin
            pressure_ready = !m[0];
            paper_empty = m[1];
            bin0_empty = m[2];
            bin1_empty = m[3];
            drive_cycle();
        end

        set_defaults();
        current_menu_state = 4'd7;
        drive_cycle();
        current_menu_state = 4'd8;
        drive_cycle();
        // Held inputs
        repeat (3) drive_cycle();
        for (int code = 11; code < 16; code++) begin
            current_menu_state = code[3:0];
            drive_cycle();
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== verilog.f ====
lcd_pkg.sv
consumable_if.sv
status_screens.sv
selection_screens.sv
brew_screen.sv
message_select.sv
message_manager.sv
tb_message_manager.sv
